// ==== udp_split_pkg.sv ====
package udp_split_pkg;

    localparam int ip_addr_w   = 32;
    localparam int udp_field_w = 16;
    localparam int data_w      = 64;
    localparam int padbytes_w  = 3;
    localparam int timestamp_w = 64;

    // Three receivers sit behind the splitter
    localparam int num_dsts = 3;
    localparam int dst_id_w = $clog2(num_dsts);

    typedef logic [ip_addr_w-1:0]   ip_addr_t;
    typedef logic [udp_field_w-1:0] udp_port_t;
    typedef logic [data_w-1:0]      data_word_t;
    typedef logic [padbytes_w-1:0]  padbytes_t;
    typedef logic [timestamp_w-1:0] timestamp_t;
    typedef logic [dst_id_w-1:0]    dst_id_t;
    typedef logic [num_dsts-1:0]    dst_vec_t;

    // Field order follows the wire order of the UDP header
    typedef struct packed {
        udp_port_t              src_port;
        udp_port_t              dst_port;
        logic [udp_field_w-1:0] length;
        logic [udp_field_w-1:0] chksum;
    } udp_hdr_t;

    typedef struct packed {
        ip_addr_t   src_ip;
        ip_addr_t   dst_ip;
        udp_hdr_t   udp_hdr;
        timestamp_t timestamp;
    } rx_hdr_t;

    typedef struct packed {
        data_word_t data;
        logic       last;
        padbytes_t  padbytes; // Unused bytes in the final beat
    } rx_data_t;

    localparam dst_id_t app_dst_id     = dst_id_t'(0);
    localparam dst_id_t log_dst_id     = dst_id_t'(1);
    localparam dst_id_t lat_log_dst_id = dst_id_t'(2);

    localparam udp_port_t app_port     = udp_port_t'(65432);
    localparam udp_port_t log_port     = udp_port_t'(60000);
    localparam udp_port_t lat_log_port = udp_port_t'(60001);

    // One entry of the port lookup table
    typedef struct packed {
        udp_port_t port;
        dst_id_t   dst_id;
    } port_entry_t;

    // Fixed contents of the lookup table, searched by udp_port_cam
    localparam port_entry_t port_table [num_dsts] = '{
        '{port: app_port,     dst_id: app_dst_id},
        '{port: log_port,     dst_id: log_dst_id},
        '{port: lat_log_port, dst_id: lat_log_dst_id}
    };

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_hdr_out,
        st_data_out,
        st_drop_data
    } ctrl_state_t;

endpackage

// ==== udp_port_cam.sv ====
`timescale 1ns/1ps

module udp_port_cam (
     input  logic                   clk
    ,input  logic                   rst

    ,input  logic                   rd_val
    ,input  udp_split_pkg::udp_port_t rd_port
    ,output logic                   rd_hit
    ,output udp_split_pkg::dst_id_t rd_dst_id
);

    logic                    match_hit;
    udp_split_pkg::dst_id_t  match_id;

    // Search every table entry in parallel
    always_comb begin
        match_hit = 1'b0;
        match_id  = '0;
        for (int i = 0; i < udp_split_pkg::num_dsts; i++) begin
            if (rd_port == udp_split_pkg::port_table[i].port) begin
                match_hit = 1'b1;
                match_id  = udp_split_pkg::port_table[i].dst_id;
            end
        end
    end

    // Result appears the cycle after the read request
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_hit    <= 1'b0;
            rd_dst_id <= '0;
        end else begin
            rd_hit <= rd_val & match_hit;
            if (rd_val) begin
                rd_dst_id <= match_id; // Held between lookups
            end
        end
    end

endmodule

// ==== udp_split_ctrl.sv ====
`timescale 1ns/1ps

module udp_split_ctrl (
     input  logic clk
    ,input  logic rst

    ,input  logic hdr_val
    ,output logic hdr_rdy

    ,input  logic data_val
    ,input  logic data_last
    ,output logic data_rdy

    ,output logic fwd_hdr_val
    ,input  logic fwd_hdr_rdy

    ,output logic fwd_data_val
    ,input  logic fwd_data_rdy

    ,input  logic table_hit
    ,output logic table_read
    ,output logic store_dst
);

    udp_split_pkg::ctrl_state_t state;
    udp_split_pkg::ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_split_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        hdr_rdy      = 1'b0;
        data_rdy     = 1'b0;
        fwd_hdr_val  = 1'b0;
        fwd_data_val = 1'b0;
        table_read   = 1'b0;
        store_dst    = 1'b0;
        state_next   = state;

        unique case (state)
            udp_split_pkg::st_idle: begin
                // Header is held by the source until we accept it
                table_read = hdr_val;
                if (hdr_val) begin
                    state_next = udp_split_pkg::st_lookup;
                end
            end

            udp_split_pkg::st_lookup: begin
                // Table result is valid now
                store_dst = 1'b1;
                if (table_hit) begin
                    state_next = udp_split_pkg::st_hdr_out;
                end else begin
                    hdr_rdy    = 1'b1; // Unknown port, swallow the header here
                    state_next = udp_split_pkg::st_drop_data;
                end
            end

            udp_split_pkg::st_hdr_out: begin
                fwd_hdr_val = hdr_val;
                hdr_rdy     = fwd_hdr_rdy;
                if (hdr_val && fwd_hdr_rdy) begin
                    state_next = udp_split_pkg::st_data_out;
                end
            end

            udp_split_pkg::st_data_out: begin
                // Beats pass straight through to the chosen receiver
                fwd_data_val = data_val;
                data_rdy     = fwd_data_rdy;
                if (data_val && fwd_data_rdy && data_last) begin
                    state_next = udp_split_pkg::st_idle;
                end
            end

            udp_split_pkg::st_drop_data: begin
                // Accept and discard until the last beat
                data_rdy = 1'b1;
                if (data_val && data_last) begin
                    state_next = udp_split_pkg::st_idle;
                end
            end

            default: begin
                state_next = udp_split_pkg::st_idle;
            end
        endcase
    end

endmodule

// ==== udp_dst_steer.sv ====
`timescale 1ns/1ps

module udp_dst_steer (
     input  logic                    clk
    ,input  logic                    rst

    ,input  logic                    store_dst
    ,input  udp_split_pkg::dst_id_t  table_dst_id

    ,input  logic                    fwd_hdr_val
    ,output logic                    fwd_hdr_rdy
    ,input  logic                    fwd_data_val
    ,output logic                    fwd_data_rdy

    ,output udp_split_pkg::dst_vec_t dst_hdr_val
    ,input  udp_split_pkg::dst_vec_t dst_hdr_rdy
    ,output udp_split_pkg::dst_vec_t dst_data_val
    ,input  udp_split_pkg::dst_vec_t dst_data_rdy
);

    udp_split_pkg::dst_id_t dst_id_reg;

    // Destination of the packet in flight, kept until the next lookup
    always_ff @(posedge clk) begin
        if (rst) begin
            dst_id_reg <= '0;
        end else if (store_dst) begin
            dst_id_reg <= table_dst_id;
        end
    end

    always_comb begin
        dst_hdr_val  = udp_split_pkg::dst_vec_t'(fwd_hdr_val) << dst_id_reg;
        dst_data_val = udp_split_pkg::dst_vec_t'(fwd_data_val) << dst_id_reg;

        fwd_hdr_rdy  = dst_hdr_rdy[dst_id_reg];
        fwd_data_rdy = dst_data_rdy[dst_id_reg];
    end

endmodule

// ==== udp_splitter.sv ====
`timescale 1ns/1ps

module udp_splitter (
     input  logic                    clk
    ,input  logic                    rst

    ,input  logic                    hdr_val
    ,input  udp_split_pkg::rx_hdr_t  hdr
    ,output logic                    hdr_rdy

    ,input  logic                    data_val
    ,input  udp_split_pkg::rx_data_t data
    ,output logic                    data_rdy

    ,output udp_split_pkg::dst_vec_t dst_hdr_val
    ,output udp_split_pkg::rx_hdr_t  dst_hdr
    ,input  udp_split_pkg::dst_vec_t dst_hdr_rdy

    ,output udp_split_pkg::dst_vec_t dst_data_val
    ,output udp_split_pkg::rx_data_t dst_data
    ,input  udp_split_pkg::dst_vec_t dst_data_rdy
);

    logic                   table_read;
    logic                   table_hit;
    udp_split_pkg::dst_id_t table_dst_id;
    logic                   store_dst;

    logic fwd_hdr_val;
    logic fwd_hdr_rdy;
    logic fwd_data_val;
    logic fwd_data_rdy;

    // Payloads go to every receiver, only the valids are steered
    assign dst_hdr  = hdr;
    assign dst_data = data;

    udp_port_cam i_cam (
         .clk       (clk                    )
        ,.rst       (rst                    )
        ,.rd_val    (table_read             )
        ,.rd_port   (hdr.udp_hdr.dst_port   )
        ,.rd_hit    (table_hit              )
        ,.rd_dst_id (table_dst_id           )
    );

    udp_split_ctrl i_ctrl (
         .clk           (clk            )
        ,.rst           (rst            )
        ,.hdr_val       (hdr_val        )
        ,.hdr_rdy       (hdr_rdy        )
        ,.data_val      (data_val       )
        ,.data_last     (data.last      )
        ,.data_rdy      (data_rdy       )
        ,.fwd_hdr_val   (fwd_hdr_val    )
        ,.fwd_hdr_rdy   (fwd_hdr_rdy    )
        ,.fwd_data_val  (fwd_data_val   )
        ,.fwd_data_rdy  (fwd_data_rdy   )
        ,.table_hit     (table_hit      )
        ,.table_read    (table_read     )
        ,.store_dst     (store_dst      )
    );

    udp_dst_steer i_steer (
         .clk           (clk            )
        ,.rst           (rst            )
        ,.store_dst     (store_dst      )
        ,.table_dst_id  (table_dst_id   )
        ,.fwd_hdr_val   (fwd_hdr_val    )
        ,.fwd_hdr_rdy   (fwd_hdr_rdy    )
        ,.fwd_data_val  (fwd_data_val   )
        ,.fwd_data_rdy  (fwd_data_rdy   )
        ,.dst_hdr_val   (dst_hdr_val    )
        ,.dst_hdr_rdy   (dst_hdr_rdy    )
        ,.dst_data_val  (dst_data_val   )
        ,.dst_data_rdy  (dst_data_rdy   )
    );

endmodule

// ==== udp_splitter_props.sv ====
`timescale 1ns/1ps

module udp_splitter_props (
     input logic                    clk
    ,input logic                    rst

    ,input udp_split_pkg::dst_vec_t dst_hdr_val
    ,input udp_split_pkg::rx_hdr_t  dst_hdr
    ,input udp_split_pkg::dst_vec_t dst_hdr_rdy

    ,input udp_split_pkg::dst_vec_t dst_data_val
    ,input udp_split_pkg::rx_data_t dst_data
    ,input udp_split_pkg::dst_vec_t dst_data_rdy
);

    udp_split_pkg::dst_vec_t hdr_taken; // Receiver of the most recent header

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_taken <= '0;
        end else if ((dst_hdr_val & dst_hdr_rdy) != '0) begin
            hdr_taken <= dst_hdr_val;
        end
    end

    a_hdr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(dst_hdr_val))
        else $error("More than one destination header valid is set");

    a_data_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(dst_data_val))
        else $error("More than one destination data valid is set");

    for (genvar i = 0; i < udp_split_pkg::num_dsts; i++) begin : g_hold
        a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
            dst_hdr_val[i] && !dst_hdr_rdy[i] |=> dst_hdr_val[i] && $stable(dst_hdr))
            else $error("Header valid of destination %0d dropped or changed before ready", i);

        a_data_hold: assert property (@(posedge clk) disable iff (rst)
            dst_data_val[i] && !dst_data_rdy[i] |=> dst_data_val[i] && $stable(dst_data))
            else $error("Data valid of destination %0d dropped or changed before ready", i);
    end

    a_data_dst: assert property (@(posedge clk) disable iff (rst)
        (dst_data_val & ~hdr_taken) == '0)
        else $error("Data valid raised at a destination that did not take the header");

endmodule

// ==== tb_udp_splitter.sv ====
`timescale 1ns/1ps

module tb_udp_splitter;

    localparam int clk_period  = 40;
    localparam int num_random  = 12;
    // Header and data beats of all tests, at most four data beats per random packet
    localparam int total_beats = 6 + 9 + 8 + num_random * 5;

    logic clk;
    logic rst;

    logic                    hdr_val;
    udp_split_pkg::rx_hdr_t  hdr;
    logic                    hdr_rdy;
    logic                    data_val;
    udp_split_pkg::rx_data_t data;
    logic                    data_rdy;
    udp_split_pkg::dst_vec_t dst_hdr_val;
    udp_split_pkg::rx_hdr_t  dst_hdr;
    udp_split_pkg::dst_vec_t dst_hdr_rdy;
    udp_split_pkg::dst_vec_t dst_data_val;
    udp_split_pkg::rx_data_t dst_data;
    udp_split_pkg::dst_vec_t dst_data_rdy;

    logic [31:0]             lfsr_state;
    logic                    rand_ready;
    udp_split_pkg::dst_vec_t ready_level;
    int                      cur_dst; // Destination of the packet on the source side, -1 for none
    int                      error_count;
    int                      check_count;

    udp_split_pkg::rx_hdr_t  exp_hdr  [udp_split_pkg::num_dsts][$];
    udp_split_pkg::rx_hdr_t  got_hdr  [udp_split_pkg::num_dsts][$];
    udp_split_pkg::rx_data_t exp_data [udp_split_pkg::num_dsts][$];
    udp_split_pkg::rx_data_t got_data [udp_split_pkg::num_dsts][$];

    udp_splitter i_dut (
         .clk          (clk         )
        ,.rst          (rst         )
        ,.hdr_val      (hdr_val     )
        ,.hdr          (hdr         )
        ,.hdr_rdy      (hdr_rdy     )
        ,.data_val     (data_val    )
        ,.data         (data        )
        ,.data_rdy     (data_rdy    )
        ,.dst_hdr_val  (dst_hdr_val )
        ,.dst_hdr      (dst_hdr     )
        ,.dst_hdr_rdy  (dst_hdr_rdy )
        ,.dst_data_val (dst_data_val)
        ,.dst_data     (dst_data    )
        ,.dst_data_rdy (dst_data_rdy)
    );

    bind udp_splitter udp_splitter_props i_props (
         .clk          (clk         )
        ,.rst          (rst         )
        ,.dst_hdr_val  (dst_hdr_val )
        ,.dst_hdr      (dst_hdr     )
        ,.dst_hdr_rdy  (dst_hdr_rdy )
        ,.dst_data_val (dst_data_val)
        ,.dst_data     (dst_data    )
        ,.dst_data_rdy (dst_data_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(rand_bit());
        end
        return v;
    endfunction

    function automatic int expected_dst(input udp_split_pkg::udp_port_t port);
        case (port)
            udp_split_pkg::app_port:     return 0;
            udp_split_pkg::log_port:     return 1;
            udp_split_pkg::lat_log_port: return 2;
            default:                     return -1;
        endcase
    endfunction

    function automatic udp_split_pkg::rx_hdr_t make_hdr(input int pkt,
                                                        input udp_split_pkg::udp_port_t port);
        udp_split_pkg::rx_hdr_t h;
        h.src_ip           = 32'h0a00_0001 + 32'(pkt);
        h.dst_ip           = 32'hc0a8_0100 + 32'(pkt);
        h.udp_hdr.src_port = 16'h4000 + 16'(pkt);
        h.udp_hdr.dst_port = port;
        h.udp_hdr.length   = 16'd8 + 16'(pkt * 8);
        h.udp_hdr.chksum   = 16'hbeef ^ 16'(pkt);
        h.timestamp        = 64'h0000_1000_0000_0000 + 64'(pkt);
        return h;
    endfunction

    task automatic compare_value(input string name, input int got, input int exp);
        check_count++;
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Readies change a little after the edge, like the source side
    initial begin : ready_drive
        forever begin
            @(posedge clk);
            #2;
            if (rand_ready) begin
                for (int i = 0; i < udp_split_pkg::num_dsts; i++) begin
                    dst_hdr_rdy[i]  = rand_bit();
                    dst_data_rdy[i] = rand_bit();
                end
            end else begin
                dst_hdr_rdy  = ready_level;
                dst_data_rdy = ready_level;
            end
        end
    end

    // Sampled mid-cycle, so a valid and ready seen here transfer on the next edge
    always @(negedge clk) begin : dst_monitor
        udp_split_pkg::dst_vec_t allowed;
        allowed = (cur_dst >= 0) ? udp_split_pkg::dst_vec_t'(1 << cur_dst) : '0;
        if (!rst) begin
            check_count++;
            if ((dst_hdr_val & ~allowed) != '0) begin
                $display("CHECK FAILED at %0t: dst_hdr_val got %b expected no bit outside %b",
                         $time, dst_hdr_val, allowed);
                error_count++;
            end
            if ((dst_data_val & ~allowed) != '0) begin
                $display("CHECK FAILED at %0t: dst_data_val got %b expected no bit outside %b",
                         $time, dst_data_val, allowed);
                error_count++;
            end
            for (int i = 0; i < udp_split_pkg::num_dsts; i++) begin
                if (dst_hdr_val[i] && dst_hdr_rdy[i]) begin
                    got_hdr[i].push_back(dst_hdr);
                end
                if (dst_data_val[i] && dst_data_rdy[i]) begin
                    got_data[i].push_back(dst_data);
                end
            end
        end
    end

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        hdr_val  = 1'b0;
        data_val = 1'b0;
        @(negedge clk);
    endtask

    task automatic source_gap(input bit gaps);
        int n;
        n = 0;
        while (gaps && n < 3 && rand_bit()) begin
            idle_cycle();
            n++;
        end
    endtask

    // Entered and left at a falling edge
    task automatic send_packet(input int pkt, input udp_split_pkg::udp_port_t port,
                               input int nbeats, input bit gaps, output int hdr_cycles);
        udp_split_pkg::rx_hdr_t  h;
        udp_split_pkg::rx_data_t beat;
        int                      d;
        h = make_hdr(pkt, port);
        d = expected_dst(port);
        if (d >= 0) begin
            exp_hdr[d].push_back(h);
        end
        source_gap(gaps);
        @(posedge clk);
        #2;
        data_val   = 1'b0;
        hdr_val    = 1'b1;
        hdr        = h;
        cur_dst    = d;
        hdr_cycles = 0;
        @(negedge clk);
        while (!hdr_rdy) begin
            @(negedge clk);
            hdr_cycles++;
        end
        check_count++;
        if (d >= 0 && !(dst_hdr_val[d] && dst_hdr_rdy[d])) begin
            $display("Header of packet %0d was accepted at %0t without a transfer to destination %0d",
                     pkt, $time, d);
            error_count++;
        end
        for (int b = 0; b < nbeats; b++) begin
            beat.data     = {32'(pkt), 32'(b)} ^ 64'h5a5a_0f0f_a5a5_f0f0;
            beat.last     = (b == nbeats - 1);
            beat.padbytes = beat.last ? 3'(pkt + 3) : 3'd0;
            if (d >= 0) begin
                exp_data[d].push_back(beat);
            end
            source_gap(gaps);
            @(posedge clk);
            #2;
            hdr_val  = 1'b0;
            data_val = 1'b1;
            data     = beat;
            @(negedge clk);
            while (!data_rdy) begin
                @(negedge clk);
            end
            check_count++;
            if (d >= 0 && !(dst_data_val[d] && dst_data_rdy[d])) begin
                $display("Beat %0d of packet %0d was accepted at %0t without a transfer",
                         b, pkt, $time);
                error_count++;
            end
        end
        @(posedge clk);
        #2;
        data_val = 1'b0;
        cur_dst  = -1;
        @(negedge clk);
    endtask

    task automatic compare_queues();
        for (int d = 0; d < udp_split_pkg::num_dsts; d++) begin
            check_count++;
            if (got_hdr[d].size() != exp_hdr[d].size()) begin
                $display("Destination %0d received %0d headers, expected %0d",
                         d, got_hdr[d].size(), exp_hdr[d].size());
                error_count++;
            end else begin
                for (int i = 0; i < exp_hdr[d].size(); i++) begin
                    if (got_hdr[d][i] !== exp_hdr[d][i]) begin
                        $display("CHECK FAILED at %0t: dst_hdr[%0d] item %0d got %h expected %h",
                                 $time, d, i, got_hdr[d][i], exp_hdr[d][i]);
                        error_count++;
                    end
                end
            end
            check_count++;
            if (got_data[d].size() != exp_data[d].size()) begin
                $display("Destination %0d received %0d data beats, expected %0d",
                         d, got_data[d].size(), exp_data[d].size());
                error_count++;
            end else begin
                for (int i = 0; i < exp_data[d].size(); i++) begin
                    if (got_data[d][i] !== exp_data[d][i]) begin
                        $display("CHECK FAILED at %0t: dst_data[%0d] beat %0d got %h expected %h",
                                 $time, d, i, got_data[d][i], exp_data[d][i]);
                        error_count++;
                    end
                end
            end
            got_hdr[d].delete();
            exp_hdr[d].delete();
            got_data[d].delete();
            exp_data[d].delete();
        end
    endtask

    task automatic test_reset_idle();
        repeat (3) begin
            compare_value("hdr_rdy", int'(hdr_rdy), 0);
            compare_value("data_rdy", int'(data_rdy), 0);
            compare_value("dst_hdr_val", int'(dst_hdr_val), 0);
            compare_value("dst_data_val", int'(dst_data_val), 0);
            @(negedge clk);
        end
    endtask

    task automatic test_app_packet();
        int cycles;
        ready_level = '1;
        send_packet(1, udp_split_pkg::app_port, 5, 1'b0, cycles);
        compare_value("cycles from hdr_val to dst_hdr_val[0]", cycles, 2);
        compare_queues();
    endtask

    task automatic test_other_ports();
        int cycles;
        send_packet(2, udp_split_pkg::log_port, 3, 1'b0, cycles);
        compare_value("cycles from hdr_val to dst_hdr_val[1]", cycles, 2);
        send_packet(3, udp_split_pkg::lat_log_port, 4, 1'b0, cycles);
        compare_value("cycles from hdr_val to dst_hdr_val[2]", cycles, 2);
        compare_queues();
    endtask

    task automatic test_unknown_port();
        int cycles;
        ready_level = '0; // A dropped packet must not depend on any receiver
        send_packet(4, 16'd5353, 4, 1'b0, cycles);
        compare_value("cycles from hdr_val to hdr_rdy on a miss", cycles, 1);
        ready_level = '1;
        send_packet(5, udp_split_pkg::app_port, 2, 1'b0, cycles);
        compare_queues();
    endtask

    task automatic test_random_mix();
        int                       cycles;
        int                       sel;
        udp_split_pkg::udp_port_t port;
        rand_ready = 1'b1;
        for (int p = 0; p < num_random; p++) begin
            sel = rand_bits(2);
            case (sel)
                0:       port = udp_split_pkg::app_port;
                1:       port = udp_split_pkg::log_port;
                2:       port = udp_split_pkg::lat_log_port;
                default: port = 16'd4789;
            endcase
            send_packet(10 + p, port, 1 + rand_bits(2), 1'b1, cycles);
        end
        compare_queues();
        rand_ready = 1'b0;
    endtask

    initial begin : watchdog
        #(total_beats * 40 * clk_period);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        hdr_val      = 1'b0;
        hdr          = '0;
        data_val     = 1'b0;
        data         = '0;
        dst_hdr_rdy  = '0;
        dst_data_rdy = '0;
        lfsr_state   = 32'hd46a_c8d6;
        rand_ready   = 1'b0;
        ready_level  = '0;
        cur_dst      = -1;
        error_count  = 0;
        check_count  = 0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);

        test_reset_idle();
        test_app_packet();
        test_other_ports();
        test_unknown_port();
        test_random_mix();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== udp_splitter.f ====
udp_split_pkg.sv
udp_port_cam.sv
udp_split_ctrl.sv
udp_dst_steer.sv
udp_splitter.sv
udp_splitter_props.sv
tb_udp_splitter.sv
